// File: Bender.yml
package:
  name: i3c_tgt_flow

sources:
  - include_dirs:
      - src
    files:
      - src/i3c_tgt_pkg.sv
      - src/tti_queue_if.sv
      - src/flow_csr_if.sv
      - src/tti_fifo.sv
      - src/flow_standby_i3c.sv
      - src/tti_csr.sv
      - src/i3c_tgt_flow_top.sv
      - target: test
        files:
          - tb/i3c_tgt_flow_assertions.sv
          - tb/tb_i3c_tgt_flow.sv

// File: sim.f
+incdir+src
src/i3c_tgt_pkg.sv
src/tti_queue_if.sv
src/flow_csr_if.sv
src/tti_fifo.sv
src/flow_standby_i3c.sv
src/tti_csr.sv
src/i3c_tgt_flow_top.sv
tb/i3c_tgt_flow_assertions.sv
tb/tb_i3c_tgt_flow.sv

// File: src/flow_csr_if.sv
// Control and event bundle between the flow controller and the register block
`timescale 1ns/10ps

interface flow_csr_if import i3c_tgt_pkg::*; ();

  // Software enable from CTRL
  logic   enable;

  // Single-cycle error events, captured as sticky flags
  logic   bad_type;
  logic   overflow;

  // Byte count of a finished write or CCC transfer
  logic   count_done;
  count_t count;

  // Command code of the current CCC transfer
  logic   ccc_valid;
  byte_t  ccc_code;

  modport flow (
    input  enable,
    output bad_type, overflow, count_done, count, ccc_valid, ccc_code
  );

  modport regs (
    output enable,
    input  bad_type, overflow, count_done, count, ccc_valid, ccc_code
  );

endinterface

// File: src/flow_standby_i3c.sv
// Flow controller: dispatches on transfer type and moves bytes between bus and TTI queues
`timescale 1ns/10ps

module flow_standby_i3c
  import i3c_tgt_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,

  // From the bus-level target FSM
  input  logic          transfer_start_i,
  input  logic          transfer_stop_i,
  input  xfer_type_t    transfer_type_i,

  // Bytes received from the bus
  input  logic          rx_byte_valid_i,
  input  byte_t         rx_byte_i,
  output logic          rx_byte_ready_o,

  // Bytes to transmit onto the bus
  output logic          tx_byte_valid_o,
  output byte_t         tx_byte_o,
  input  logic          tx_byte_ready_i,

  tti_queue_if.producer rxq,
  tti_queue_if.popper   txq,
  flow_csr_if.flow      csr
);

  flow_state_e state_q, state_d;
  xfer_type_t  type_q;

  logic   in_rx_state;
  logic   rx_accept;
  logic   to_code;
  logic   to_queue;
  logic   ccc_first_q;
  logic   push_valid_q;
  byte_t  push_data_q;
  count_t count_q;
  logic   count_done_q;
  logic   ccc_valid_q;
  byte_t  ccc_code_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (csr.enable) begin
          state_d = TransferWait;
        end
      end
      TransferWait: begin
        if (transfer_start_i) begin
          state_d = TransferStart;
        end
      end
      TransferStart: begin
        if (transfer_stop_i) begin
          state_d = TransferWait;
        end else begin
          case (type_q)
            XferWrite: state_d = TransferWrite;
            XferRead:  state_d = TransferRead;
            XferCcc:   state_d = TransferCCC;
            // Illegal type drops back, enable brings us to wait again
            default:   state_d = Idle;
          endcase
        end
      end
      TransferWrite, TransferRead, TransferCCC: begin
        if (transfer_stop_i) begin
          state_d = TransferWait;
        end
      end
      default: begin
        state_d = Idle;
      end
    endcase
    // Disable wins over everything
    if (!csr.enable) begin
      state_d = Idle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      type_q  <= XferWrite;
    end else begin
      state_q <= state_d;
      // Type travels with the start pulse
      if ((state_q == TransferWait) && transfer_start_i) begin
        type_q <= transfer_type_i;
      end
    end
  end

  assign csr.bad_type = (state_q == TransferStart) && (type_q == XferIllegal);

  // RX path, bus bytes are gated by state and by queue room
  assign in_rx_state     = (state_q == TransferWrite) || (state_q == TransferCCC);
  assign rx_byte_ready_o = in_rx_state && !rxq.full;
  assign rx_accept       = rx_byte_valid_i && rx_byte_ready_o;
  // First CCC byte is the command code
  assign to_code         = rx_accept && (state_q == TransferCCC) && ccc_first_q;
  assign to_queue        = rx_accept && !to_code;
  // Bus offers a byte we cannot take, it has to hold it
  assign csr.overflow    = in_rx_state && rx_byte_valid_i && rxq.full;

  // One-entry push stage in front of the RX queue
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_valid_q <= 1'b0;
    end else if (!csr.enable) begin
      push_valid_q <= 1'b0;
    end else if (to_queue) begin
      push_valid_q <= 1'b1;
    end else if (rxq.ready) begin
      push_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (to_queue) begin
      push_data_q <= rx_byte_i;
    end
    if (to_code) begin
      ccc_code_q <= rx_byte_i;
    end
  end

  assign rxq.valid = push_valid_q;
  assign rxq.data  = push_data_q;

  // Byte count, CCC code capture and end-of-transfer report
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q      <= '0;
      ccc_first_q  <= 1'b0;
      count_done_q <= 1'b0;
      ccc_valid_q  <= 1'b0;
    end else begin
      count_done_q <= in_rx_state && transfer_stop_i && csr.enable;
      ccc_valid_q  <= to_code;
      if (state_q == TransferStart) begin
        count_q     <= '0;
        ccc_first_q <= 1'b1;
      end else begin
        // Saturate at all ones
        if (to_queue && (count_q != '1)) begin
          count_q <= count_q + 1'b1;
        end
        if (to_code) begin
          ccc_first_q <= 1'b0;
        end
      end
    end
  end

  // Count already holds a byte accepted together with stop
  assign csr.count_done = count_done_q;
  assign csr.count      = count_q;
  assign csr.ccc_valid  = ccc_valid_q;
  assign csr.ccc_code   = ccc_code_q;

  // TX path, queue head straight onto the bus
  assign tx_byte_valid_o = (state_q == TransferRead) && !txq.empty;
  assign tx_byte_o       = txq.data;
  assign txq.ready       = (state_q == TransferRead) && tx_byte_ready_i && txq.valid;

endmodule

// File: src/i3c_tgt_cfg.svh
// I3C target flow core configuration: queue depth, data width and register map
`ifndef I3C_TGT_CFG_SVH
`define I3C_TGT_CFG_SVH

// Entries per TTI queue, must be a power of two
`define I3C_TGT_FIFO_DEPTH 8

// Width of one bus or queue byte
`define I3C_TGT_DATA_WIDTH 8

// Width of the saturating write byte counter
`define I3C_TGT_COUNT_WIDTH 8

// Register map, one byte-wide register per address
`define I3C_TGT_ADDR_CTRL   2'd0
`define I3C_TGT_ADDR_STATUS 2'd1
`define I3C_TGT_ADDR_RXCNT  2'd2
`define I3C_TGT_ADDR_CCC    2'd3

// Bit positions inside CTRL and STATUS
`define I3C_TGT_CTRL_ENABLE_BIT     0
`define I3C_TGT_STATUS_BAD_TYPE_BIT 0
`define I3C_TGT_STATUS_OVERFLOW_BIT 1

`endif

// File: src/i3c_tgt_flow_top.sv
// I3C target flow core top: flow controller, RX and TX queues and register block
`timescale 1ns/10ps

`include "i3c_tgt_cfg.svh"

module i3c_tgt_flow_top
  import i3c_tgt_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // Bus-level target FSM side
  input  logic       transfer_start_i,
  input  logic       transfer_stop_i,
  input  xfer_type_t transfer_type_i,
  input  logic       rx_byte_valid_i,
  input  byte_t      rx_byte_i,
  output logic       rx_byte_ready_o,
  output logic       tx_byte_valid_o,
  output byte_t      tx_byte_o,
  input  logic       tx_byte_ready_i,

  // Software side
  output logic       rx_pop_valid_o,
  input  logic       rx_pop_ready_i,
  output byte_t      rx_pop_data_o,
  input  logic       tx_push_valid_i,
  output logic       tx_push_ready_o,
  input  byte_t      tx_push_data_i,
  input  logic       reg_we_i,
  input  csr_addr_t  reg_addr_i,
  input  byte_t      reg_wdata_i,
  output byte_t      reg_rdata_o
);

  tti_queue_if rxq_if ();
  tti_queue_if txq_push_if ();
  tti_queue_if txq_pop_if ();
  flow_csr_if  csr_if ();

  // Queues stay empty while the core is disabled
  logic queue_flush;
  assign queue_flush = !csr_if.enable;

  // Software pushes TX bytes
  assign txq_push_if.valid = tx_push_valid_i;
  assign txq_push_if.data  = tx_push_data_i;
  assign tx_push_ready_o   = txq_push_if.ready;
  // Level of the TX queue as seen by its reader
  assign txq_pop_if.full   = txq_push_if.full;
  assign txq_pop_if.empty  = txq_push_if.empty;

  flow_standby_i3c flow_standby_i3c_i (
    .clk_i,
    .rst_ni,
    .transfer_start_i,
    .transfer_stop_i,
    .transfer_type_i,
    .rx_byte_valid_i,
    .rx_byte_i,
    .rx_byte_ready_o,
    .tx_byte_valid_o,
    .tx_byte_o,
    .tx_byte_ready_i,
    .rxq (rxq_if),
    .txq (txq_pop_if),
    .csr (csr_if)
  );

  tti_fifo #(.Depth(`I3C_TGT_FIFO_DEPTH)) rx_fifo_i (
    .clk_i,
    .rst_ni,
    .flush_i    (queue_flush),
    .wr         (rxq_if),
    .rd_valid_o (rx_pop_valid_o),
    .rd_data_o  (rx_pop_data_o),
    .rd_ready_i (rx_pop_ready_i)
  );

  tti_fifo #(.Depth(`I3C_TGT_FIFO_DEPTH)) tx_fifo_i (
    .clk_i,
    .rst_ni,
    .flush_i    (queue_flush),
    .wr         (txq_push_if),
    .rd_valid_o (txq_pop_if.valid),
    .rd_data_o  (txq_pop_if.data),
    .rd_ready_i (txq_pop_if.ready)
  );

  tti_csr tti_csr_i (
    .clk_i,
    .rst_ni,
    .reg_we_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .csr (csr_if)
  );

endmodule

// File: src/i3c_tgt_pkg.sv
// I3C target flow core types: bytes, counts, register addresses and flow states
package i3c_tgt_pkg;

  `include "i3c_tgt_cfg.svh"

  // One data byte on the bus stream or in a queue
  typedef logic [`I3C_TGT_DATA_WIDTH-1:0] byte_t;

  // Byte count of one write transfer, saturating
  typedef logic [`I3C_TGT_COUNT_WIDTH-1:0] count_t;

  // Register block address
  typedef logic [1:0] csr_addr_t;

  // Transfer type handed over by the bus-level FSM with the start pulse
  typedef logic [1:0] xfer_type_t;

  localparam xfer_type_t XferWrite   = 2'b00;
  localparam xfer_type_t XferRead    = 2'b01;
  localparam xfer_type_t XferCcc     = 2'b10;
  // Never produced by a healthy bus FSM
  localparam xfer_type_t XferIllegal = 2'b11;

  // Flow controller states
  typedef enum logic [2:0] {
    Idle,
    TransferWait,
    TransferStart,
    TransferWrite,
    TransferRead,
    TransferCCC
  } flow_state_e;

endpackage

// File: src/tti_csr.sv
// TTI register block: enable, sticky error flags, write byte count and CCC code
`timescale 1ns/10ps

`include "i3c_tgt_cfg.svh"

module tti_csr
  import i3c_tgt_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      reg_we_i,
  input  csr_addr_t reg_addr_i,
  input  byte_t     reg_wdata_i,
  output byte_t     reg_rdata_o,
  flow_csr_if.regs  csr
);

  logic   enable_q;
  logic   bad_type_q;
  logic   overflow_q;
  count_t rxcnt_q;
  byte_t  ccc_q;
  logic   ctrl_we;
  logic   status_we;

  assign ctrl_we   = reg_we_i && (reg_addr_i == `I3C_TGT_ADDR_CTRL);
  assign status_we = reg_we_i && (reg_addr_i == `I3C_TGT_ADDR_STATUS);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q   <= 1'b0;
      bad_type_q <= 1'b0;
      overflow_q <= 1'b0;
      rxcnt_q    <= '0;
      ccc_q      <= '0;
    end else begin
      if (ctrl_we) begin
        enable_q <= reg_wdata_i[`I3C_TGT_CTRL_ENABLE_BIT];
      end
      // Sticky flags, a new event beats a write-1-to-clear
      if (csr.bad_type) begin
        bad_type_q <= 1'b1;
      end else if (status_we && reg_wdata_i[`I3C_TGT_STATUS_BAD_TYPE_BIT]) begin
        bad_type_q <= 1'b0;
      end
      if (csr.overflow) begin
        overflow_q <= 1'b1;
      end else if (status_we && reg_wdata_i[`I3C_TGT_STATUS_OVERFLOW_BIT]) begin
        overflow_q <= 1'b0;
      end
      // RXCNT and CCC are read only
      if (csr.count_done) begin
        rxcnt_q <= csr.count;
      end
      if (csr.ccc_valid) begin
        ccc_q <= csr.ccc_code;
      end
    end
  end

  assign csr.enable = enable_q;

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      `I3C_TGT_ADDR_CTRL: reg_rdata_o[`I3C_TGT_CTRL_ENABLE_BIT] = enable_q;
      `I3C_TGT_ADDR_STATUS: begin
        reg_rdata_o[`I3C_TGT_STATUS_BAD_TYPE_BIT] = bad_type_q;
        reg_rdata_o[`I3C_TGT_STATUS_OVERFLOW_BIT] = overflow_q;
      end
      `I3C_TGT_ADDR_RXCNT: reg_rdata_o = rxcnt_q;
      default: reg_rdata_o = ccc_q;
    endcase
  end

endmodule

// File: src/tti_fifo.sv
// Synchronous fall-through FIFO with flush for the TTI RX and TX queues
`timescale 1ns/10ps

`include "i3c_tgt_cfg.svh"

module tti_fifo
  import i3c_tgt_pkg::*;
#(
  parameter int unsigned Depth = `I3C_TGT_FIFO_DEPTH
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  tti_queue_if.consumer     wr,
  output logic              rd_valid_o,
  output byte_t             rd_data_o,
  input  logic              rd_ready_i
);

  localparam int unsigned PtrW = $clog2(Depth);
  localparam logic [PtrW:0] FullCnt = (PtrW + 1)'(Depth);
  localparam logic [PtrW:0] LastCnt = (PtrW + 1)'(Depth - 1);

  // Queue storage for Depth bytes
  byte_t           mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW:0]   count_q;
  logic            push;
  logic            pop;

  // No pushes while flushing
  assign wr.ready = !flush_i && (count_q != FullCnt);
  assign wr.empty = (count_q == '0);
  // Full also counts a push in flight from the registered producer
  assign wr.full  = (count_q == FullCnt) || ((count_q == LastCnt) && wr.valid);

  assign push = wr.valid && wr.ready;
  assign pop  = rd_valid_o && rd_ready_i;

  // Head of queue with zero latency
  assign rd_valid_o = (count_q != '0);
  assign rd_data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr.data;
    end
  end

  // Pointers wrap on their own since Depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the level
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: src/tti_queue_if.sv
// TTI queue port bundle between the flow controller and one FIFO
`timescale 1ns/10ps

interface tti_queue_if import i3c_tgt_pkg::*; ();

  // Byte handshake, a byte moves when valid and ready are both high
  logic  valid;
  logic  ready;
  byte_t data;

  // Queue level seen by the side that is not the FIFO
  logic  full;
  logic  empty;

  // Side that pushes bytes into the FIFO
  modport producer (
    output valid, data,
    input  ready, full, empty
  );

  // FIFO write side, reports its level
  modport consumer (
    input  valid, data,
    output ready, full, empty
  );

  // Side that pops bytes from the FIFO head
  modport popper (
    input  valid, data, full, empty,
    output ready
  );

endinterface

// File: tb/i3c_tgt_flow_assertions.sv
// Concurrent checks on reset values and byte stream handshakes of the flow core
`timescale 1ns/10ps

module i3c_tgt_flow_assertions
  import i3c_tgt_pkg::*;
(
  input logic  clk_i,
  input logic  rst_ni,
  input logic  rx_valid_i,
  input logic  rx_ready_i,
  input byte_t rx_data_i,
  input logic  tx_valid_i,
  input logic  tx_ready_i,
  input logic  pop_valid_i,
  input logic  push_valid_i,
  input logic  push_ready_i,
  input logic  enable_i
);

  // TX queue level rebuilt from software pushes and bus pops
  int tx_level;

  // Disable flushes the queue
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_level <= 0;
    end else if (!enable_i) begin
      tx_level <= 0;
    end else begin
      tx_level <= tx_level + int'(push_valid_i && push_ready_i)
                           - int'(tx_valid_i && tx_ready_i);
    end
  end

  // Nothing offered or accepted while reset is held
  assert property (@(posedge clk_i) !rst_ni |-> !rx_ready_i && !tx_valid_i && !pop_valid_i)
    else $error("byte stream valid or ready high during reset");

  // Bus side keeps a stalled byte unchanged
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_valid_i && !rx_ready_i |=> rx_valid_i && $stable(rx_data_i))
    else $error("stalled rx byte dropped or changed before acceptance");

  // TX stream only offers bytes that sit in the queue
  assert property (@(posedge clk_i) disable iff (!rst_ni) tx_valid_i |-> tx_level > 0)
    else $error("tx_byte_valid_o high while the TX queue is empty");

endmodule

bind i3c_tgt_flow_top i3c_tgt_flow_assertions i3c_tgt_flow_assertions_i (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .rx_valid_i   (rx_byte_valid_i),
  .rx_ready_i   (rx_byte_ready_o),
  .rx_data_i    (rx_byte_i),
  .tx_valid_i   (tx_byte_valid_o),
  .tx_ready_i   (tx_byte_ready_i),
  .pop_valid_i  (rx_pop_valid_o),
  .push_valid_i (tx_push_valid_i),
  .push_ready_i (tx_push_ready_o),
  .enable_i     (csr_if.enable)
);

// File: tb/tb_i3c_tgt_flow.sv
// Directed testbench for the I3C target flow core with queues and registers
`timescale 1ns/10ps

`include "i3c_tgt_cfg.svh"

module tb_i3c_tgt_flow import i3c_tgt_pkg::*; ();

  localparam int ClkPeriod = 40;
  localparam int Depth     = `I3C_TGT_FIFO_DEPTH;
  // Longest wait for any single handshake
  localparam int WaitLimit = 64;
  // Rough cycle budget per test, reset first, doubled for margin
  localparam int WatchdogCycles =
    2 * (10 + 40 + 80 + 80 + (60 + 8 * Depth) + 80 + 120);

  // Selectors for the flag being waited on
  localparam int SelRxReady     = 0;
  localparam int SelTxPushReady = 1;
  localparam int SelRxPopValid  = 2;
  localparam int SelTxValid     = 3;

  logic       clk_i;
  logic       rst_ni;
  logic       transfer_start_i;
  logic       transfer_stop_i;
  xfer_type_t transfer_type_i;
  logic       rx_byte_valid_i;
  byte_t      rx_byte_i;
  logic       rx_byte_ready_o;
  logic       tx_byte_valid_o;
  byte_t      tx_byte_o;
  logic       tx_byte_ready_i;
  logic       rx_pop_valid_o;
  logic       rx_pop_ready_i;
  byte_t      rx_pop_data_o;
  logic       tx_push_valid_i;
  logic       tx_push_ready_o;
  byte_t      tx_push_data_i;
  logic       reg_we_i;
  csr_addr_t  reg_addr_i;
  byte_t      reg_wdata_i;
  byte_t      reg_rdata_o;

  integer seed;
  int     errors;
  int     checks;
  int     tests_run;

  i3c_tgt_flow_top i3c_tgt_flow_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, tests did not finish", WatchdogCycles);
    $display("TEST FAILED");
    $finish;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      $display("ERROR t=%0t: %s", $time, what);
      errors++;
    end
  endtask

  function automatic logic flag_level(input int sel);
    case (sel)
      SelRxReady:     return rx_byte_ready_o;
      SelTxPushReady: return tx_push_ready_o;
      SelRxPopValid:  return rx_pop_valid_o;
      default:        return tx_byte_valid_o;
    endcase
  endfunction

  // Polls at falling edges, where all outputs have settled
  task automatic wait_flag(input int sel, input string what);
    int n;
    n = 0;
    @(negedge clk_i);
    while ((flag_level(sel) !== 1'b1) && (n < WaitLimit)) begin
      @(negedge clk_i);
      n++;
    end
    check_true(flag_level(sel), {"timed out waiting for ", what});
  endtask

  task automatic write_reg(input csr_addr_t addr, input byte_t data);
    @(posedge clk_i);
    reg_we_i    <= 1'b1;
    reg_addr_i  <= addr;
    reg_wdata_i <= data;
    @(posedge clk_i);
    reg_we_i    <= 1'b0;
  endtask

  // Read data is combinational on the address
  task automatic read_reg(input csr_addr_t addr, output byte_t data);
    @(posedge clk_i);
    reg_addr_i <= addr;
    @(negedge clk_i);
    data = reg_rdata_o;
  endtask

  task automatic wait_reg(input csr_addr_t addr, input byte_t mask, input byte_t exp,
                          input string name);
    byte_t d;
    int    n;
    n = 0;
    read_reg(addr, d);
    while (((d & mask) !== exp) && (n < WaitLimit)) begin
      read_reg(addr, d);
      n++;
    end
    check_val(name, d & mask, exp);
  endtask

  task automatic start_xfer(input xfer_type_t t);
    @(posedge clk_i);
    transfer_start_i <= 1'b1;
    transfer_type_i  <= t;
    @(posedge clk_i);
    transfer_start_i <= 1'b0;
  endtask

  task automatic stop_xfer();
    @(posedge clk_i);
    transfer_stop_i <= 1'b1;
    @(posedge clk_i);
    transfer_stop_i <= 1'b0;
  endtask

  // Byte stays on the bus until the core takes it
  task automatic send_byte(input byte_t b);
    @(posedge clk_i);
    rx_byte_valid_i <= 1'b1;
    rx_byte_i       <= b;
    wait_flag(SelRxReady, "rx_byte_ready_o");
    @(posedge clk_i);
    rx_byte_valid_i <= 1'b0;
  endtask

  task automatic push_tx(input byte_t b);
    @(posedge clk_i);
    tx_push_valid_i <= 1'b1;
    tx_push_data_i  <= b;
    wait_flag(SelTxPushReady, "tx_push_ready_o");
    @(posedge clk_i);
    tx_push_valid_i <= 1'b0;
  endtask

  task automatic pop_byte(output byte_t b);
    @(posedge clk_i);
    rx_pop_ready_i <= 1'b1;
    wait_flag(SelRxPopValid, "rx_pop_valid_o");
    b = rx_pop_data_o;
    @(posedge clk_i);
    rx_pop_ready_i <= 1'b0;
  endtask

  task automatic recv_tx(output byte_t b);
    wait_flag(SelTxValid, "tx_byte_valid_o");
    b = tx_byte_o;
    @(posedge clk_i);
    tx_byte_ready_i <= 1'b1;
    @(posedge clk_i);
    tx_byte_ready_i <= 1'b0;
  endtask

  task automatic report(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("[done] %s: no errors", name);
    end else begin
      $display("[done] %s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_reset_enable();
    byte_t b;
    byte_t d;
    int    e0;
    e0 = errors;
    for (int a = 0; a < 4; a++) begin
      read_reg(csr_addr_t'(a), d);
      check_val("reg_rdata_o", d, 8'h00);
    end
    check_val("rx_byte_ready_o", rx_byte_ready_o, 1'b0);
    check_val("tx_byte_valid_o", tx_byte_valid_o, 1'b0);
    check_val("rx_pop_valid_o", rx_pop_valid_o, 1'b0);
    write_reg(`I3C_TGT_ADDR_CTRL, 8'h01);
    read_reg(`I3C_TGT_ADDR_CTRL, d);
    check_val("CTRL reg_rdata_o", d, 8'h01);
    // One byte through a write transfer
    start_xfer(XferWrite);
    b = byte_t'($random(seed));
    send_byte(b);
    stop_xfer();
    pop_byte(d);
    check_val("rx_pop_data_o", d, b);
    report("reset and enable", e0);
  endtask

  task automatic test_private_write();
    byte_t sent[$];
    byte_t b;
    byte_t d;
    int    e0;
    e0 = errors;
    start_xfer(XferWrite);
    for (int i = 0; i < 5; i++) begin
      b = byte_t'($random(seed));
      sent.push_back(b);
      send_byte(b);
    end
    stop_xfer();
    foreach (sent[i]) begin
      pop_byte(d);
      check_val("rx_pop_data_o", d, sent[i]);
    end
    wait_reg(`I3C_TGT_ADDR_RXCNT, 8'hff, 8'd5, "RXCNT reg_rdata_o");
    report("private write", e0);
  endtask

  task automatic test_private_read();
    byte_t sent[$];
    byte_t b;
    byte_t d;
    int    e0;
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      b = byte_t'($random(seed));
      sent.push_back(b);
      push_tx(b);
    end
    start_xfer(XferRead);
    foreach (sent[i]) begin
      recv_tx(d);
      check_val("tx_byte_o", d, sent[i]);
    end
    // Queue drained, stream goes quiet
    @(negedge clk_i);
    check_val("tx_byte_valid_o", tx_byte_valid_o, 1'b0);
    stop_xfer();
    report("private read", e0);
  endtask

  task automatic test_back_pressure();
    byte_t sent[$];
    byte_t b;
    byte_t d;
    int    e0;
    e0 = errors;
    start_xfer(XferWrite);
    for (int i = 0; i < Depth; i++) begin
      b = byte_t'($random(seed));
      sent.push_back(b);
      send_byte(b);
    end
    // One byte beyond depth is offered and held
    b = byte_t'($random(seed));
    sent.push_back(b);
    @(posedge clk_i);
    rx_byte_valid_i <= 1'b1;
    rx_byte_i       <= b;
    repeat (3) begin
      @(negedge clk_i);
      check_val("rx_byte_ready_o", rx_byte_ready_o, 1'b0);
    end
    wait_reg(`I3C_TGT_ADDR_STATUS, 8'h02, 8'h02, "STATUS.overflow reg_rdata_o");
    // Room for one more lets the held byte in
    pop_byte(d);
    check_val("rx_pop_data_o", d, sent[0]);
    wait_flag(SelRxReady, "rx_byte_ready_o after drain");
    @(posedge clk_i);
    rx_byte_valid_i <= 1'b0;
    for (int i = 1; i <= Depth; i++) begin
      pop_byte(d);
      check_val("rx_pop_data_o", d, sent[i]);
    end
    @(negedge clk_i);
    check_val("rx_pop_valid_o", rx_pop_valid_o, 1'b0);
    stop_xfer();
    write_reg(`I3C_TGT_ADDR_STATUS, 8'h02);
    wait_reg(`I3C_TGT_ADDR_STATUS, 8'h02, 8'h00, "STATUS.overflow reg_rdata_o");
    report("back-pressure", e0);
  endtask

  task automatic test_ccc();
    byte_t sent[$];
    byte_t b;
    byte_t d;
    int    e0;
    e0 = errors;
    start_xfer(XferCcc);
    for (int i = 0; i < 4; i++) begin
      b = byte_t'($random(seed));
      sent.push_back(b);
      send_byte(b);
    end
    stop_xfer();
    // First byte is the command code, the rest is payload
    wait_reg(`I3C_TGT_ADDR_CCC, 8'hff, sent[0], "CCC reg_rdata_o");
    for (int i = 1; i < 4; i++) begin
      pop_byte(d);
      check_val("rx_pop_data_o", d, sent[i]);
    end
    @(negedge clk_i);
    check_val("rx_pop_valid_o", rx_pop_valid_o, 1'b0);
    report("CCC transfer", e0);
  endtask

  task automatic test_illegal_disable();
    int e0;
    e0 = errors;
    start_xfer(XferIllegal);
    wait_reg(`I3C_TGT_ADDR_STATUS, 8'h01, 8'h01, "STATUS.bad_type reg_rdata_o");
    write_reg(`I3C_TGT_ADDR_STATUS, 8'h01);
    wait_reg(`I3C_TGT_ADDR_STATUS, 8'h01, 8'h00, "STATUS.bad_type reg_rdata_o");
    // Leave bytes in both queues
    push_tx(byte_t'($random(seed)));
    push_tx(byte_t'($random(seed)));
    start_xfer(XferWrite);
    send_byte(byte_t'($random(seed)));
    send_byte(byte_t'($random(seed)));
    stop_xfer();
    wait_flag(SelRxPopValid, "rx_pop_valid_o before disable");
    write_reg(`I3C_TGT_ADDR_CTRL, 8'h00);
    @(posedge clk_i);
    @(negedge clk_i);
    check_val("rx_pop_valid_o", rx_pop_valid_o, 1'b0);
    // A read after re-enable finds the TX queue empty
    write_reg(`I3C_TGT_ADDR_CTRL, 8'h01);
    start_xfer(XferRead);
    repeat (4) begin
      @(negedge clk_i);
      check_val("tx_byte_valid_o", tx_byte_valid_o, 1'b0);
    end
    stop_xfer();
    report("illegal type and disable", e0);
  endtask

  initial begin
    rst_ni           = 1'b1;
    transfer_start_i = 1'b0;
    transfer_stop_i  = 1'b0;
    transfer_type_i  = XferWrite;
    rx_byte_valid_i  = 1'b0;
    rx_byte_i        = '0;
    tx_byte_ready_i  = 1'b0;
    rx_pop_ready_i   = 1'b0;
    tx_push_valid_i  = 1'b0;
    tx_push_data_i   = '0;
    reg_we_i         = 1'b0;
    reg_addr_i       = '0;
    reg_wdata_i      = '0;
    seed             = 32'hd11d_7d5a;
    errors           = 0;
    checks           = 0;
    tests_run        = 0;
    // Clean falling reset edge ahead of the first clock edge
    #(ClkPeriod / 4);
    rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    test_reset_enable();
    test_private_write();
    test_private_read();
    test_back_pressure();
    test_ccc();
    test_illegal_disable();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
